// ==== logic/interp_params.svh ====
`ifndef INTERP_PARAMS_SVH
`define INTERP_PARAMS_SVH

// sample width, signed.
`define INTERP_DATA_W 16

// number of result words.
`define INTERP_MEM_DEPTH 16

// loop index and result address width.
`define INTERP_IDX_W 4

`define INTERP_APB_AW 8

`endif

// ==== logic/interp_pkg.sv ====
package interp_pkg;

    typedef enum logic [3:0] {
        IDLE,
        CLEAR,
        SETUP,
        DIV_START,
        DIV_WAIT,
        LOOP_MUL,
        MUL_WAIT,
        LOOP_WRITE,
        WRITE_ENDS,
        FINISH,
        ABORT
    } fsm_state_t;

    // read back in bits 2:0 of STATUS.
    typedef struct packed {
        logic busy;
        logic done;
        logic error;
    } status_t;

    typedef enum logic [7:0] {
        CTRL        = 8'h00, // bit 0 start, bit 1 clear.
        STATUS      = 8'h04,
        T0          = 8'h08,
        U0          = 8'h0c,
        T1          = 8'h10,
        U1          = 8'h14,
        RESULT_BASE = 8'h40  // word k sits at 0x40 + 4*k.
    } apb_reg_t;

endpackage

// ==== logic/interp_ctrl_if.sv ====
`timescale 1ns/1ps

interface interp_ctrl_if;

    logic       load_ops;
    logic       div_start;
    logic       mul_start;
    logic       idx_step;
    logic       mem_we;
    logic [1:0] mem_sel;   // 2'b00 interpolated, 2'b10 u0 at 0, 2'b11 u1 at n.
    logic       clear_mem;

    logic       range_bad;
    logic       div_done;
    logic       mul_done;
    logic       idx_last;

    modport ctrl (
        output load_ops, div_start, mul_start, idx_step, mem_we, mem_sel, clear_mem,
        input  range_bad, div_done, mul_done, idx_last
    );

    modport dp (
        input  load_ops, div_start, mul_start, idx_step, mem_we, mem_sel, clear_mem,
        output range_bad, div_done, mul_done, idx_last
    );

endinterface

// ==== logic/seq_divider.sv ====
`timescale 1ns/1ps
`include "interp_params.svh"

module seq_divider (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      start,
    input  logic [`INTERP_DATA_W-1:0] dividend,
    input  logic [`INTERP_DATA_W-1:0] divisor,
    output logic [`INTERP_DATA_W-1:0] quotient,
    output logic                      done
);
    localparam int W  = `INTERP_DATA_W;
    localparam int CW = $clog2(W);
    localparam logic [CW-1:0] LAST = CW'(W - 2);

    logic [W-1:0]  rem;
    logic [W-1:0]  dvs;
    logic [W-1:0]  rem_in;
    logic [W-1:0]  quo_in;
    logic [W-1:0]  dvs_in;
    logic [W:0]    shifted;
    logic [W+1:0]  trial;
    logic [CW-1:0] cnt;
    logic          run;

    // the load cycle already retires the first quotient bit.
    assign rem_in  = start ? '0 : rem;
    assign quo_in  = start ? dividend : quotient;
    assign dvs_in  = start ? divisor : dvs;
    assign shifted = {rem_in, quo_in[W-1]};
    assign trial   = {1'b0, shifted} - {2'b00, dvs_in};

    always_ff @(posedge clk)
    begin
        if (start || run)
        begin
            quotient <= {quo_in[W-2:0], ~trial[W+1]};
            rem      <= trial[W+1] ? shifted[W-1:0] : trial[W-1:0]; // restore on a negative trial.
        end
        if (start)
            dvs <= divisor;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            run  <= 1'b0;
            cnt  <= '0;
            done <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            if (start)
            begin
                run <= 1'b1;
                cnt <= '0;
            end
            else if (run)
            begin
                cnt <= cnt + 1'b1;
                if (cnt == LAST)
                begin
                    run  <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

endmodule

// ==== logic/seq_multiplier.sv ====
`timescale 1ns/1ps
`include "interp_params.svh"

module seq_multiplier (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    start,
    input  logic [`INTERP_DATA_W-1:0]               multiplicand,
    input  logic [`INTERP_IDX_W-1:0]                multiplier,
    output logic [`INTERP_DATA_W+`INTERP_IDX_W-1:0] product,
    output logic                                    done
);
    localparam int W  = `INTERP_DATA_W;
    localparam int IW = `INTERP_IDX_W;
    localparam int PW = W + IW;
    localparam int CW = $clog2(IW);
    localparam logic [CW-1:0] LAST = CW'(IW - 2);

    logic [PW-1:0] mcand_sh;
    logic [IW-2:0] bits_left;
    logic [CW-1:0] cnt;
    logic          run;

    always_ff @(posedge clk)
    begin
        if (start)
        begin
            product   <= multiplier[0] ? PW'(multiplicand) : '0; // bit 0 is added while loading.
            mcand_sh  <= PW'({multiplicand, 1'b0});
            bits_left <= multiplier[IW-1:1];
        end
        else if (run)
        begin
            if (bits_left[0])
                product <= product + mcand_sh;
            mcand_sh  <= mcand_sh << 1;
            bits_left <= bits_left >> 1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            run  <= 1'b0;
            cnt  <= '0;
            done <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            if (start)
            begin
                run <= 1'b1;
                cnt <= '0;
            end
            else if (run)
            begin
                cnt <= cnt + 1'b1;
                if (cnt == LAST)
                begin
                    run  <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

endmodule

// ==== logic/interp_regs.sv ====
`timescale 1ns/1ps
`include "interp_params.svh"

module interp_regs (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [`INTERP_APB_AW-1:0]  paddr,
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  logic [31:0]                pwdata,
    input  interp_pkg::status_t        status,
    input  logic [`INTERP_DATA_W-1:0]  rd_data,
    output logic [31:0]                prdata,
    output logic                       pready,
    output logic                       pslverr,
    output logic                       start_cmd,
    output logic                       clear_cmd,
    output logic [`INTERP_DATA_W-1:0]  t0,
    output logic [`INTERP_DATA_W-1:0]  u0,
    output logic [`INTERP_DATA_W-1:0]  t1,
    output logic [`INTERP_DATA_W-1:0]  u1,
    output logic [`INTERP_IDX_W-1:0]   rd_addr
);
    import interp_pkg::*;

    localparam int W = `INTERP_DATA_W;

    logic access;
    logic in_result;
    logic is_point;
    logic mapped;
    logic wr_protect;
    logic wr_ok;

    function automatic logic [31:0] sext(input logic [W-1:0] v);
        return {{(32 - W){v[W-1]}}, v};
    endfunction

    assign access    = psel & penable;
    assign in_result = (paddr & 8'hc3) == RESULT_BASE; // aligned words 0x40 to 0x7c.
    assign is_point  = paddr inside {T0, U0, T1, U1};
    assign mapped    = in_result | is_point | (paddr == CTRL) | (paddr == STATUS);

    // the engine owns the points and the command word while it runs.
    assign wr_protect = status.busy & (is_point | (paddr == CTRL));

    assign pready  = 1'b1;
    assign pslverr = access & (~mapped
                               | (pwrite & (in_result | (paddr == STATUS)))
                               | (pwrite & wr_protect));
    assign wr_ok   = access & pwrite & ~pslverr;
    assign rd_addr = paddr[`INTERP_IDX_W+1:2];

    always_ff @(posedge clk)
    begin
        if (wr_ok)
        begin
            case (paddr)
                T0:      t0 <= pwdata[W-1:0];
                U0:      u0 <= pwdata[W-1:0];
                T1:      t1 <= pwdata[W-1:0];
                U1:      u1 <= pwdata[W-1:0];
                default: ;
            endcase
        end
    end

    // clear takes priority when both command bits are written.
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            start_cmd <= 1'b0;
            clear_cmd <= 1'b0;
        end
        else
        begin
            start_cmd <= wr_ok & (paddr == CTRL) & pwdata[0] & ~pwdata[1];
            clear_cmd <= wr_ok & (paddr == CTRL) & pwdata[1];
        end
    end

    always_comb
    begin
        prdata = '0;
        if (in_result)
            prdata = sext(rd_data);
        else
        begin
            case (paddr)
                STATUS:  prdata = {{(32 - $bits(status_t)){1'b0}}, status};
                T0:      prdata = sext(t0);
                U0:      prdata = sext(u0);
                T1:      prdata = sext(t1);
                U1:      prdata = sext(u1);
                default: prdata = '0; // CTRL reads back as zero.
            endcase
        end
    end

    a_cmd_not_busy: assert property (@(posedge clk) disable iff (rst)
        (start_cmd || clear_cmd) |-> !status.busy);

endmodule

// ==== logic/interp_fsm.sv ====
`timescale 1ns/1ps

module interp_fsm (
    input  logic                clk,
    input  logic                rst,
    input  logic                start_cmd,
    input  logic                clear_cmd,
    interp_ctrl_if.ctrl         ctrl,
    output interp_pkg::status_t status
);
    import interp_pkg::*;

    fsm_state_t state;
    logic       end_phase; // low while u0 goes to address 0, high for u1 at n.

    // enables decode straight from the state.
    assign ctrl.load_ops  = state == SETUP;
    assign ctrl.div_start = state == DIV_START;
    assign ctrl.mul_start = state == LOOP_MUL;
    assign ctrl.clear_mem = state == CLEAR;
    assign ctrl.mem_we    = state == LOOP_WRITE | state == WRITE_ENDS | state == CLEAR;
    assign ctrl.mem_sel   = (state == WRITE_ENDS) ? {1'b1, end_phase} : 2'b00;

    // the index moves to k = 1 as the slope arrives, then once per written sample.
    assign ctrl.idx_step  = state == LOOP_WRITE | (state == DIV_WAIT & ctrl.div_done);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state     <= IDLE;
            end_phase <= 1'b0;
            status    <= '0;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    if (clear_cmd)
                    begin
                        state  <= CLEAR;
                        status <= '{busy: 1'b1, done: 1'b0, error: 1'b0};
                    end
                    else if (start_cmd)
                    begin
                        state  <= SETUP;
                        status <= '{busy: 1'b1, done: 1'b0, error: 1'b0};
                    end
                end
                CLEAR:
                begin
                    if (ctrl.idx_last)
                    begin
                        state       <= IDLE;
                        status.busy <= 1'b0;
                    end
                end
                SETUP:
                begin
                    if (ctrl.range_bad)
                    begin
                        state        <= ABORT; // nothing is written on a bad range.
                        status.busy  <= 1'b0;
                        status.error <= 1'b1;
                    end
                    else
                        state <= DIV_START;
                end
                DIV_START:
                    state <= DIV_WAIT;
                DIV_WAIT:
                begin
                    // n of 1 has no inner points.
                    if (ctrl.div_done)
                        state <= ctrl.idx_last ? WRITE_ENDS : LOOP_MUL;
                end
                LOOP_MUL:
                    state <= MUL_WAIT;
                MUL_WAIT:
                begin
                    if (ctrl.mul_done)
                        state <= LOOP_WRITE;
                end
                LOOP_WRITE:
                    state <= ctrl.idx_last ? WRITE_ENDS : LOOP_MUL;
                WRITE_ENDS:
                begin
                    end_phase <= ~end_phase;
                    if (end_phase)
                    begin
                        state       <= FINISH;
                        status.busy <= 1'b0;
                        status.done <= 1'b1;
                    end
                end
                FINISH:
                    state <= IDLE;
                ABORT:
                    state <= IDLE;
                default:
                begin
                    state     <= IDLE;
                    end_phase <= 1'b0;
                end
            endcase
        end
    end

    a_write_while_busy: assert property (@(posedge clk) disable iff (rst)
        ctrl.mem_we |-> status.busy);

endmodule

// ==== logic/interp_datapath.sv ====
`timescale 1ns/1ps
`include "interp_params.svh"

module interp_datapath (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [`INTERP_DATA_W-1:0] t0,
    input  logic [`INTERP_DATA_W-1:0] u0,
    input  logic [`INTERP_DATA_W-1:0] t1,
    input  logic [`INTERP_DATA_W-1:0] u1,
    input  logic [`INTERP_IDX_W-1:0]  rd_addr,
    interp_ctrl_if.dp                 dp,
    output logic [`INTERP_DATA_W-1:0] rd_data
);
    localparam int W  = `INTERP_DATA_W;
    localparam int IW = `INTERP_IDX_W;
    localparam int PW = W + IW;

    logic [W:0]    n_full;
    logic [W:0]    diff;
    logic [W:0]    diff_abs;
    logic [IW-1:0] n_q;
    logic          neg_q;
    logic [W-1:0]  mag_q;
    logic [W-1:0]  u0_q;
    logic [W-1:0]  u1_q;
    logic [IW-1:0] idx;
    logic [IW-1:0] clr_addr;
    logic [W-1:0]  quotient;
    logic [PW-1:0] product;
    logic [PW-1:0] prod_signed;
    logic [W-1:0]  interp;
    logic [IW-1:0] wr_addr;
    logic [W-1:0]  wr_data;
    logic [W-1:0]  mem [`INTERP_MEM_DEPTH];

    // one extra bit keeps the differences of two signed samples exact.
    assign n_full       = {t1[W-1], t1} - {t0[W-1], t0};
    assign dp.range_bad = n_full[W] | (n_full[W-1:IW] != '0) | (n_full[IW-1:0] == '0);
    assign diff         = {u1[W-1], u1} - {u0[W-1], u0};
    assign diff_abs     = diff[W] ? -diff : diff;

    always_ff @(posedge clk)
    begin
        if (dp.load_ops)
        begin
            n_q   <= n_full[IW-1:0];
            neg_q <= diff[W];
            mag_q <= diff_abs[W-1:0];
            u0_q  <= u0;
            u1_q  <= u1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            idx      <= '0;
            clr_addr <= '0;
        end
        else
        begin
            if (dp.load_ops)
                idx <= '0;
            else if (dp.idx_step)
                idx <= idx + 1'b1;
            if (dp.clear_mem)
                clr_addr <= clr_addr + 1'b1; // wraps back to zero after the last entry.
        end
    end

    assign dp.idx_last = dp.clear_mem ? (clr_addr == '1) : (idx == n_q - 1'b1);

    seq_divider u_div (
        .clk      (clk),
        .rst      (rst),
        .start    (dp.div_start),
        .dividend (mag_q),
        .divisor  ({{(W - IW){1'b0}}, n_q}),
        .quotient (quotient),
        .done     (dp.div_done)
    );

    seq_multiplier u_mul (
        .clk          (clk),
        .rst          (rst),
        .start        (dp.mul_start),
        .multiplicand (quotient),
        .multiplier   (idx),
        .product      (product),
        .done         (dp.mul_done)
    );

    // truncation toward zero falls out of dividing the magnitude.
    assign prod_signed = neg_q ? -product : product;
    assign interp      = u0_q + prod_signed[W-1:0];

    always_comb
    begin
        if (dp.clear_mem)
        begin
            wr_addr = clr_addr;
            wr_data = '0;
        end
        else if (dp.mem_sel[1])
        begin
            wr_addr = dp.mem_sel[0] ? n_q : '0;
            wr_data = dp.mem_sel[0] ? u1_q : u0_q;
        end
        else
        begin
            wr_addr = idx;
            wr_data = interp;
        end
    end

    always_ff @(posedge clk)
    begin
        if (dp.mem_we)
            mem[wr_addr] <= wr_data;
    end

    assign rd_data = mem[rd_addr];

    a_addr_in_span: assert property (@(posedge clk) disable iff (rst)
        dp.mem_we && !dp.clear_mem |-> wr_addr <= n_q);

endmodule

// ==== logic/interp_top.sv ====
`timescale 1ns/1ps
`include "interp_params.svh"

module interp_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [`INTERP_APB_AW-1:0] paddr,
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  logic [31:0]               pwdata,
    output logic [31:0]               prdata,
    output logic                      pready,
    output logic                      pslverr
);
    import interp_pkg::*;

    status_t                   status;
    logic                      start_cmd;
    logic                      clear_cmd;
    logic [`INTERP_DATA_W-1:0] t0;
    logic [`INTERP_DATA_W-1:0] u0;
    logic [`INTERP_DATA_W-1:0] t1;
    logic [`INTERP_DATA_W-1:0] u1;
    logic [`INTERP_IDX_W-1:0]  rd_addr;
    logic [`INTERP_DATA_W-1:0] rd_data;

    interp_ctrl_if u_ctrl_if ();

    interp_regs u_regs (
        .clk       (clk),
        .rst       (rst),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .status    (status),
        .rd_data   (rd_data),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .start_cmd (start_cmd),
        .clear_cmd (clear_cmd),
        .t0        (t0),
        .u0        (u0),
        .t1        (t1),
        .u1        (u1),
        .rd_addr   (rd_addr)
    );

    interp_fsm u_fsm (
        .clk       (clk),
        .rst       (rst),
        .start_cmd (start_cmd),
        .clear_cmd (clear_cmd),
        .ctrl      (u_ctrl_if.ctrl),
        .status    (status)
    );

    interp_datapath u_datapath (
        .clk     (clk),
        .rst     (rst),
        .t0      (t0),
        .u0      (u0),
        .t1      (t1),
        .u1      (u1),
        .rd_addr (rd_addr),
        .dp      (u_ctrl_if.dp),
        .rd_data (rd_data)
    );

endmodule

// ==== sim/interp_tb.sv ====
`timescale 1ns/1ps
`include "interp_params.svh"

module interp_tb;

    localparam logic [7:0] A_CTRL   = 8'h00;
    localparam logic [7:0] A_STATUS = 8'h04;
    localparam logic [7:0] A_T0     = 8'h08;
    localparam logic [7:0] A_U0     = 8'h0c;
    localparam logic [7:0] A_T1     = 8'h10;
    localparam logic [7:0] A_U1     = 8'h14;
    localparam logic [7:0] A_RESULT = 8'h40;
    localparam int DEPTH = `INTERP_MEM_DEPTH;

    typedef struct packed {
        int t0;
        int u0;
        int t1;
        int u1;
        int err;
        int slope;
    } pattern_t;

    logic        clk;
    logic        rst;
    logic [7:0]  paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    int          errors;
    int          checks;
    int          tests;
    logic        tests_known;
    logic [31:0] rng;

    interp_top u_interp_top (
        .clk     (clk),
        .rst     (rst),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] next_random(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // setup cycle, access cycle, then one idle cycle. Responses are taken mid access.
    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
        @(posedge clk);
        paddr  <= addr;
        pwdata <= data;
        pwrite <= 1'b1;
        psel   <= 1'b1;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        err = pslverr;
        expect_equal("apb write pready", 32'h1, {31'd0, pready});
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
        @(posedge clk);
        paddr  <= addr;
        pwrite <= 1'b0;
        psel   <= 1'b1;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        data = prdata;
        err  = pslverr;
        expect_equal("apb read pready", 32'h1, {31'd0, pready});
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic expect_equal(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("ERROR %s expected %h actual %h", name, exp, act);
        end
    endtask

    // status reads busy in bit 2, done in bit 1 and error in bit 0.
    task automatic wait_idle(output logic [31:0] st);
        logic e;
        apb_read(A_STATUS, st, e);
        while (st[2])
            apb_read(A_STATUS, st, e);
    endtask

    task automatic run_case(input string name, input pattern_t p);
        logic [31:0] snap [DEPTH];
        logic [31:0] d;
        logic        e;
        int          ev;
        if (p.err != 0)
            for (int k = 0; k < DEPTH; k++)
                apb_read(8'(A_RESULT + 4 * k), snap[k], e);
        apb_write(A_T0, p.t0, e);
        apb_write(A_U0, p.u0, e);
        apb_write(A_T1, p.t1, e);
        apb_write(A_U1, p.u1, e);
        apb_write(A_CTRL, 32'h1, e);
        wait_idle(d);
        expect_equal({name, " status"}, (p.err != 0) ? 32'h1 : 32'h2, d);
        if (p.err != 0)
            for (int k = 0; k < DEPTH; k++)
            begin
                apb_read(8'(A_RESULT + 4 * k), d, e);
                expect_equal($sformatf("%s kept word %0d", name, k), snap[k], d);
            end
        else
            for (int k = 0; k <= p.t1 - p.t0; k++)
            begin
                ev = (k == p.t1 - p.t0) ? p.u1 : p.u0 + p.slope * k;
                apb_read(8'(A_RESULT + 4 * k), d, e);
                expect_equal($sformatf("%s word %0d", name, k), {{16{ev[15]}}, ev[15:0]}, d);
            end
    endtask

    task automatic clear_memory(input string name);
        logic [31:0] d;
        logic        e;
        apb_write(A_CTRL, 32'h2, e);
        wait_idle(d);
        expect_equal({name, " status"}, 32'h0, d);
        for (int k = 0; k < DEPTH; k++)
        begin
            apb_read(8'(A_RESULT + 4 * k), d, e);
            expect_equal($sformatf("%s word %0d", name, k), 32'h0, d);
        end
    endtask

    initial
    begin
        wait (tests_known);
        repeat (tests * 200) @(posedge clk);
        $display("timeout: the tests did not finish within %0d cycles", tests * 200);
        $display("ERRORS FOUND");
        $finish;
    end

    initial
    begin
        pattern_t        pats [$];
        pattern_t        p;
        logic [31:0]     d;
        logic            e;
        logic [8*96-1:0] header;
        int              fd;
        int              t0, u0, t1, u1, er, sl;
        errors      = 0;
        checks      = 0;
        tests       = 0;
        tests_known = 1'b0;
        rng         = 32'hefba;
        rst         = 1'b1;
        paddr       = '0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        pwdata      = '0;

        fd = $fopen("sim/interp_patterns.txt", "r");
        if (fd == 0)
        begin
            errors++;
            $display("could not open the pattern file sim/interp_patterns.txt");
        end
        else
        begin
            void'($fgets(header, fd)); // column header line.
            while ($fscanf(fd, "%d %d %d %d %d %d", t0, u0, t1, u1, er, sl) == 6)
                pats.push_back('{t0, u0, t1, u1, er, sl});
            $fclose(fd);
        end

        repeat (10) @(posedge clk);
        rst <= 1'b0;
        tests       = pats.size() + 12; // patterns, random runs and the directed steps.
        tests_known = 1'b1;

        clear_memory("clear after reset");
        foreach (pats[i])
            run_case($sformatf("pattern %0d", i), pats[i]);
        p = '{0, 5, 0, 9, 1, 0};
        run_case("abort before clear", p);
        clear_memory("clear after abort");

        apb_read(8'h20, d, e);
        expect_equal("unmapped read pslverr", 32'h1, {31'd0, e});
        apb_write(8'h44, 32'h55, e);
        expect_equal("result write pslverr", 32'h1, {31'd0, e});

        // a long run, so the point registers are still locked for the T0 write.
        apb_write(A_T0, 32'h0, e);
        apb_write(A_U0, 32'h0, e);
        apb_write(A_T1, 32'd15, e);
        apb_write(A_U1, 32'd1500, e);
        apb_write(A_CTRL, 32'h1, e);
        apb_write(A_T0, 32'h7, e);
        expect_equal("busy T0 write pslverr", 32'h1, {31'd0, e});
        wait_idle(d);
        apb_read(A_T0, d, e);
        expect_equal("T0 after refused write", 32'h0, d);

        for (int i = 0; i < 8; i++)
        begin
            rng   = next_random(rng);
            p.t0  = int'(rng[7:0]) - 128;
            p.t1  = p.t0 + ((i == 0) ? 1 : 1 + int'(rng[11:8]) % 15); // first run has n of 1.
            p.u0  = int'(rng[23:12]) - 2048;
            rng   = next_random(rng);
            p.u1  = int'(rng[11:0]) - 2048;
            p.err = 0;
            p.slope = (p.u1 - p.u0) / (p.t1 - p.t0);
            run_case($sformatf("random %0d", i), p);
        end

        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

// ==== sim/interp_patterns.txt ====
# t0 u0 t1 u1 error slope, decimal; error 1 means a range abort
0 0 10 100 0 10
0 100 10 0 0 -10
5 -7 12 20 0 3
3 10 10 -10 0 -2
-4 1000 11 -1000 0 -133
0 -500 15 500 0 66
100 7 101 -9 0 -16
2 0 9 1 0 0
2 0 9 -1 0 0
0 -32768 15 32767 0 4369
0 32767 15 -32768 0 -4369
7 50 9 51 0 0
-8 -3 -1 -17 0 -2
1 0 14 -100 0 -7
10 5 10 9 1 0
10 5 4 9 1 0
0 1 16 2 1 0
-100 0 100 0 1 0
20 -40 35 -10 0 2

// ==== project.f ====
+incdir+logic
logic/interp_pkg.sv
logic/interp_ctrl_if.sv
logic/seq_divider.sv
logic/seq_multiplier.sv
logic/interp_regs.sv
logic/interp_fsm.sv
logic/interp_datapath.sv
logic/interp_top.sv
sim/interp_tb.sv

// ==== Makefile ====
# Verilator build and run of the interpolation engine testbench.

SHELL     := /bin/bash
VERILATOR ?= verilator
TOP       ?= interp_tb
FILELIST  ?= project.f
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, fail on reported errors"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	set -o pipefail; ./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "simulation failed"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
